//--- Bender.yml
package:
  name: frontend

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/riscv_pkg.sv
      - common/frontend_pkg.sv
      - rtl/fetch.sv
      - rtl/instr_mem.sv
      - rtl/decode.sv
      - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/frontend_tb.sv

//--- common/frontend_pkg.sv
/*
 * Front-end transport types
 * Redirect requests into fetch, fetched words and decoded instructions
 */
`include "frontend_settings.svh"
`default_nettype none

package frontend_pkg;

    import riscv_pkg::*;

    typedef logic [`FRONTEND_TAG_WIDTH-1:0] tag_t;

    // Trap and CSR side of the core, plus a jump from a later stage
    typedef struct packed {
        logic        machine_return;
        logic        exception_raised;
        logic        interrupt_ack;
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic        jump;
        logic [31:0] jump_target;
    } redirect_t;

    // Address of the word on the memory read port and the path it belongs to
    typedef struct packed {
        logic [31:0] pc;
        tag_t        tag;
    } fetch_out_t;

    // Fields of one instruction as decode hands it on
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        // Already sign-extended for the format of the opcode
        logic [31:0] imm;
    } decoded_t;

endpackage

`default_nettype wire

//--- common/frontend_settings.svh
/*
 * Front-end build settings
 * Reset address, instruction memory depth and redirect tag width
 */
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// First instruction fetched after reset
`define FRONTEND_START_ADDRESS 32'h0000_0000

// Instruction memory holds 2**N words, so 8 gives 1 KiB of program space
`define FRONTEND_IMEM_WORDS_LOG2 8

// Wrong-path words are told apart by this tag
// Three bits give eight redirects before the value wraps
`define FRONTEND_TAG_WIDTH 3

`endif

//--- common/riscv_pkg.sv
/*
 * RISC-V RV32I encodings
 * Major opcodes and the base instruction formats as views of one word
 */
`default_nettype none

package riscv_pkg;

    // Major opcodes of the base set, found in bits [6:0] of every word
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // Register to register operations
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    // Immediate operations, loads, JALR and SYSTEM
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    // Stores split the immediate around rs2 and rs1
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    // Branches scramble the offset bits and drop bit 0
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    // LUI and AUIPC carry the upper twenty bits
    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    // JAL offset, again with bit 0 implied zero
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One fetched word, read through whichever format its opcode selects
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

`default_nettype wire

//--- list.f
+incdir+common
common/riscv_pkg.sv
common/frontend_pkg.sv
rtl/fetch.sv
rtl/instr_mem.sv
rtl/decode.sv
rtl/frontend_top.sv
tests/frontend_tb.sv

//--- rtl/decode.sv
/*
 * Decode stage
 * Drops wrong-path words by tag, splits each word into its fields and
 * sign-extended immediate, and sends JAL targets back to fetch
 */
`include "frontend_settings.svh"
`default_nettype none

module decode import riscv_pkg::*; import frontend_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        hold_i,
    input  fetch_out_t  fetch_i,
    input  logic [31:0] instr_i,
    input  redirect_t   redirect_i,
    output logic        jump_o,
    output logic [31:0] jump_target_o,
    output decoded_t    dec_o
);

    instr_u      word;
    tag_t        expected_tag;
    logic        external_redirect;
    logic        tag_match;
    logic        word_valid;
    logic        is_jal;
    logic [31:0] imm;
    decoded_t    dec_next;

    assign word = instr_i;

    // Redirects from later stages are older than the word sitting here
    assign external_redirect = redirect_i.machine_return
                             | redirect_i.exception_raised
                             | redirect_i.interrupt_ack
                             | redirect_i.jump;

    // A word from a path that has since been left behind carries an old tag
    // A redirect arriving this cycle also kills the word in decode
    assign tag_match  = (fetch_i.tag == expected_tag);
    assign word_valid = tag_match & ~external_redirect;

    // Count the same redirects as fetch, so both sides agree on the path
    always_ff @(posedge clk) begin
        if (reset) begin
            expected_tag <= '0;
        end else if (jump_o | external_redirect) begin
            expected_tag <= expected_tag + 1'b1;
        end
    end

    // The opcode picks the format the immediate is read from
    always_comb begin
        case (word.r_fmt.opcode)
            LOAD, OP_IMM, JALR, SYSTEM: begin
                imm = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
            end
            STORE: begin
                imm = {{20{word.s_fmt.imm_11_5[6]}}, word.s_fmt.imm_11_5,
                       word.s_fmt.imm_4_0};
            end
            BRANCH: begin
                imm = {{19{word.b_fmt.imm_12}}, word.b_fmt.imm_12, word.b_fmt.imm_11,
                       word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};
            end
            LUI, AUIPC: begin
                imm = {word.u_fmt.imm_31_12, 12'b0};
            end
            JAL: begin
                imm = {{11{word.j_fmt.imm_20}}, word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                       word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};
            end
            // Register operations and unknown opcodes carry no immediate
            default: begin
                imm = '0;
            end
        endcase
    end

    // Raw fields come straight from the R view
    // For formats without rd or rs2 those bits are simply immediate bits
    always_comb begin
        dec_next.valid  = word_valid;
        dec_next.pc     = fetch_i.pc;
        dec_next.opcode = word.r_fmt.opcode;
        dec_next.rd     = word.r_fmt.rd;
        dec_next.rs1    = word.r_fmt.rs1;
        dec_next.rs2    = word.r_fmt.rs2;
        dec_next.funct3 = word.r_fmt.funct3;
        dec_next.funct7 = word.r_fmt.funct7;
        dec_next.imm    = imm;
    end

    // JAL resolves here, no need to wait for execute
    // Waiting out the hold keeps this a single pulse per JAL
    assign is_jal        = (word.j_fmt.opcode == JAL);
    assign jump_o        = word_valid & is_jal & ~hold_i;
    assign jump_target_o = fetch_i.pc + imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_o.valid <= 1'b0;
        end else if (!hold_i) begin
            dec_o <= dec_next;
        end
    end

    // The word after a JAL was fetched on the old path and must be dropped
    single_jump_pulse: assert property (
        @(posedge clk) disable iff (reset)
        jump_o |=> !jump_o
    );

endmodule

`default_nettype wire

//--- rtl/fetch.sv
/*
 * Fetch stage
 * Holds the program counter, picks the next address by redirect priority
 * and tags every word with the path it was fetched on
 */
`include "frontend_settings.svh"
`default_nettype none

module fetch import frontend_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  logic        hazard_i,
    input  logic        jump_i,
    input  logic [31:0] jump_target_i,
    input  redirect_t   redirect_i,
    output logic [31:0] instruction_address_o,
    output fetch_out_t  fetch_o
);

    logic [31:0] pc;
    tag_t        current_tag;
    tag_t        next_tag;
    logic        can_propagate;
    logic        redirect_event;

    // A free cycle is one where nothing downstream asks us to wait
    assign can_propagate = ~(stall_i | hazard_i);

    assign redirect_event = jump_i
                          | redirect_i.exception_raised
                          | redirect_i.interrupt_ack
                          | redirect_i.machine_return;

    // Redirects load the PC even while stalled
    // Only the sequential step waits for a free cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FRONTEND_START_ADDRESS;
        end else if (redirect_i.machine_return) begin
            pc <= redirect_i.mepc;
        end else if (redirect_i.exception_raised | redirect_i.interrupt_ack) begin
            pc <= redirect_i.mtvec;
        end else if (jump_i) begin
            pc <= jump_target_i;
        end else if (can_propagate) begin
            pc <= pc + 32'd4;
        end
    end

    // The memory registers the read, so it sees the PC directly
    assign instruction_address_o = pc;

    // Every redirect opens a new path, so the tag moves on by one
    // current_tag always names the path of the word at the PC
    assign next_tag = redirect_event ? tag_t'(current_tag + 1'b1) : current_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_tag <= '0;
        end else begin
            current_tag <= next_tag;
        end
    end

    // Registered copy of PC and tag, in step with the memory read register
    // The reset tag differs from the one decode expects, so the word read
    // while reset is high never counts as valid
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_o.pc  <= `FRONTEND_START_ADDRESS;
            fetch_o.tag <= '1;
        end else if (can_propagate) begin
            fetch_o.pc  <= pc;
            fetch_o.tag <= current_tag;
        end
    end

    // Trap vectors and jump targets come from other stages and must be aligned
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

    // A machine return beats an exception raised in the same cycle
    mret_over_exception: assert property (
        @(posedge clk) disable iff (reset)
        redirect_i.machine_return && redirect_i.exception_raised
            |=> pc == $past(redirect_i.mepc)
    );

endmodule

`default_nettype wire

//--- rtl/frontend_top.sv
/*
 * RV32I front end
 * Fetch, instruction memory and decode, with JAL redirects fed back
 * from decode and traps taken from the ports
 */
`default_nettype none

module frontend_top import frontend_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  logic        hazard_i,
    input  redirect_t   redirect_i,
    input  logic        imem_we_i,
    input  logic [31:0] imem_addr_i,
    input  logic [31:0] imem_wdata_i,
    output decoded_t    dec_o
);

    logic        hold;
    logic [31:0] instruction_address;
    logic [31:0] instr;
    fetch_out_t  fetch_out;
    logic        dec_jump;
    logic [31:0] dec_jump_target;
    logic        jump;
    logic [31:0] jump_target;

    // Memory read register and decode register both wait on either level
    assign hold = stall_i | hazard_i;

    // The decode JAL target is taken when both ask at once
    assign jump        = dec_jump | redirect_i.jump;
    assign jump_target = dec_jump ? dec_jump_target : redirect_i.jump_target;

    fetch u_fetch (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .hazard_i              (hazard_i),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .redirect_i            (redirect_i),
        .instruction_address_o (instruction_address),
        .fetch_o               (fetch_out)
    );

    instr_mem u_instr_mem (
        .clk     (clk),
        .addr_i  (instruction_address),
        .instr_o (instr),
        .we_i    (imem_we_i),
        .waddr_i (imem_addr_i),
        .wdata_i (imem_wdata_i),
        .hold_i  (hold)
    );

    decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .hold_i        (hold),
        .fetch_i       (fetch_out),
        .instr_i       (instr),
        .redirect_i    (redirect_i),
        .jump_o        (dec_jump),
        .jump_target_o (dec_jump_target),
        .dec_o         (dec_o)
    );

endmodule

`default_nettype wire

//--- rtl/instr_mem.sv
/*
 * Instruction memory
 * Word array with a registered read port that can hold its output,
 * and a write port for loading the program
 */
`include "frontend_settings.svh"
`default_nettype none

module instr_mem (
    input  logic        clk,
    input  logic [31:0] addr_i,
    output logic [31:0] instr_o,
    input  logic        we_i,
    input  logic [31:0] waddr_i,
    input  logic [31:0] wdata_i,
    input  logic        hold_i
);

    localparam int unsigned words_log2 = `FRONTEND_IMEM_WORDS_LOG2;
    localparam int unsigned words      = 1 << words_log2;

    logic [31:0]           mem [words];
    logic [words_log2-1:0] read_index;
    logic [words_log2-1:0] write_index;

    // Byte addresses, so the two low bits never select a word
    assign read_index  = addr_i[words_log2+1:2];
    assign write_index = waddr_i[words_log2+1:2];

    // Loading port, used while the core is held in reset
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[write_index] <= wdata_i;
        end
    end

    // Holding the read keeps the word paired with the fetch register
    always_ff @(posedge clk) begin
        if (!hold_i) begin
            instr_o <= mem[read_index];
        end
    end

    write_word_aligned: assert property (
        @(posedge clk)
        we_i |-> waddr_i[1:0] == 2'b00
    );

endmodule

`default_nettype wire

//--- tests/frontend_tb.sv
/*
 * Front-end testbench
 * Loads a small program, then runs sequential, jump, stall and trap
 * scenarios while concurrent assertions follow the decoded stream
 */
`include "frontend_settings.svh"
`default_nettype none

module frontend_tb import riscv_pkg::*, frontend_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned mem_words    = 1 << `FRONTEND_IMEM_WORDS_LOG2;
    localparam int unsigned prog_words   = 96;
    // The whole run takes a little under 200 cycles
    localparam int unsigned cycle_limit  = 400;
    localparam logic [31:0] handler_addr = 32'h0000_0080;

    logic        clk;
    logic        reset;
    logic        stall_i;
    logic        hazard_i;
    redirect_t   redirect_i;
    logic        imem_we_i;
    logic [31:0] imem_addr_i;
    logic [31:0] imem_wdata_i;
    decoded_t    dec_o;

    // What the program holds at each word, written down while it is built
    opcode_e     exp_op   [mem_words];
    logic [4:0]  exp_rd   [mem_words];
    logic [31:0] exp_imm  [mem_words];
    logic [31:0] exp_word [mem_words];

    logic [31:0] exp_pc;
    logic        dec_fresh;
    logic [`FRONTEND_IMEM_WORDS_LOG2-1:0] dec_index;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    integer      seed = 32'hfaa6;

    frontend_top DUT (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .hazard_i     (hazard_i),
        .redirect_i   (redirect_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .dec_o        (dec_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // A hung wait is cut off by this watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles before the tests finished", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    assign dec_index = dec_o.pc[`FRONTEND_IMEM_WORDS_LOG2+1:2];

    // RV32I encodings straight from the ISA manual
    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [20:0] offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    // A JAL continues at pc + imm, everything else at the next word
    function automatic logic [31:0] next_valid_pc(input logic [31:0] pc);
        logic [`FRONTEND_IMEM_WORDS_LOG2-1:0] index;
        index = pc[`FRONTEND_IMEM_WORDS_LOG2+1:2];
        if (exp_op[index] == JAL) begin
            return pc + exp_imm[index];
        end
        return pc + 32'd4;
    endfunction

    // Reference model of the next valid PC on dec_o
    // dec_fresh marks a dec_o that was loaded on the edge before
    // A trap throws away every younger word, so it overrides the step
    always @(posedge clk) begin
        if (reset) begin
            exp_pc    <= `FRONTEND_START_ADDRESS;
            dec_fresh <= 1'b0;
        end else begin
            dec_fresh <= !(stall_i || hazard_i);
            if (redirect_i.machine_return) begin
                exp_pc <= redirect_i.mepc;
            end else if (redirect_i.exception_raised || redirect_i.interrupt_ack) begin
                exp_pc <= redirect_i.mtvec;
            end else if (redirect_i.jump) begin
                exp_pc <= redirect_i.jump_target;
            end else if (dec_fresh && dec_o.valid) begin
                exp_pc <= next_valid_pc(dec_o.pc);
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] t=%0t %s expected 0x%h got 0x%h", $time, name, expected, actual);
        errors++;
    endtask

    pc_follows_model: assert property (
        @(posedge clk) disable iff (reset)
        dec_fresh && dec_o.valid |-> dec_o.pc == exp_pc
    ) else report_mismatch("dec_o.pc", $sampled(exp_pc), $sampled(dec_o.pc));

    opcode_matches: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> dec_o.opcode == exp_op[dec_index]
    ) else report_mismatch("dec_o.opcode", 32'(exp_op[$sampled(dec_index)]),
                           32'($sampled(dec_o.opcode)));

    rd_matches: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> dec_o.rd == exp_rd[dec_index]
    ) else report_mismatch("dec_o.rd", 32'(exp_rd[$sampled(dec_index)]),
                           32'($sampled(dec_o.rd)));

    imm_matches: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> dec_o.imm == exp_imm[dec_index]
    ) else report_mismatch("dec_o.imm", exp_imm[$sampled(dec_index)], $sampled(dec_o.imm));

    // Raw fields sit at their R-format bit positions whatever the opcode
    rs1_matches: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> dec_o.rs1 == exp_word[dec_index][19:15]
    ) else report_mismatch("dec_o.rs1", 32'(exp_word[$sampled(dec_index)][19:15]),
                           32'($sampled(dec_o.rs1)));

    rs2_matches: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> dec_o.rs2 == exp_word[dec_index][24:20]
    ) else report_mismatch("dec_o.rs2", 32'(exp_word[$sampled(dec_index)][24:20]),
                           32'($sampled(dec_o.rs2)));

    funct3_matches: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> dec_o.funct3 == exp_word[dec_index][14:12]
    ) else report_mismatch("dec_o.funct3", 32'(exp_word[$sampled(dec_index)][14:12]),
                           32'($sampled(dec_o.funct3)));

    funct7_matches: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> dec_o.funct7 == exp_word[dec_index][31:25]
    ) else report_mismatch("dec_o.funct7", 32'(exp_word[$sampled(dec_index)][31:25]),
                           32'($sampled(dec_o.funct7)));

    // Stall or hazard freezes the decode register for the next edge
    output_holds: assert property (
        @(posedge clk) disable iff (reset)
        stall_i || hazard_i |=> $stable(dec_o)
    ) else begin
        $display("[ERROR] t=%0t dec_o changed while stall or hazard was high", $time);
        errors++;
    end

    // The two words behind the JAL are never reached on a good path
    wrong_path_dropped: assert property (
        @(posedge clk) disable iff (reset)
        dec_o.valid |-> !(dec_o.pc inside {32'h24, 32'h28})
    ) else begin
        $display("[ERROR] t=%0t wrong-path word at 0x%h came out as valid",
                 $time, $sampled(dec_o.pc));
        errors++;
    end

    // Inputs change and outputs are read 2 ns after each edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // ADDI everywhere with fields that follow the word address
    // Word 8 (0x20) is a JAL forward by 16
    task automatic load_program();
        int          i;
        logic [11:0] imm12;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        for (i = 0; i < prog_words; i++) begin
            imm12 = {i[3:0], i[7:0]} ^ 12'h9c5;
            rd    = 5'(i % 31 + 1);
            rs1   = 5'(i * 7);
            if (i == 8) begin
                imem_wdata_i = encode_jal(5'd1, 21'd16);
                exp_op[i]    = JAL;
                exp_rd[i]    = 5'd1;
                exp_imm[i]   = 32'd16;
            end else begin
                imem_wdata_i = encode_addi(rd, rs1, imm12);
                exp_op[i]    = OP_IMM;
                exp_rd[i]    = rd;
                exp_imm[i]   = {{20{imm12[11]}}, imm12};
            end
            exp_word[i] = imem_wdata_i;
            imem_we_i   = 1'b1;
            imem_addr_i = 32'(i * 4);
            next_cycle();
        end
        imem_we_i = 1'b0;
    endtask

    task automatic wait_valid_pc(input logic [31:0] target, input int limit);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < limit) begin
            next_cycle();
            waited++;
            seen = dec_o.valid && (dec_o.pc == target);
        end
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for a valid word at 0x%h",
                     limit, target);
            errors++;
        end
    endtask

    // Raises a trap request for one cycle and leaves mepc and mtvec in place
    task automatic pulse_trap(input logic mret, input logic exception,
                              input logic [31:0] mepc, input logic [31:0] mtvec);
        redirect_i.mepc             = mepc;
        redirect_i.mtvec            = mtvec;
        redirect_i.machine_return   = mret;
        redirect_i.exception_raised = exception;
        next_cycle();
        redirect_i.machine_return   = 1'b0;
        redirect_i.exception_raised = 1'b0;
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    initial begin
        int          mark;
        logic [31:0] r;
        reset        = 1'b1;
        stall_i      = 1'b0;
        hazard_i     = 1'b0;
        redirect_i   = '0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;

        // Reset stays high while the program loads, then five more cycles
        next_cycle();
        load_program();
        repeat (5) next_cycle();
        reset = 1'b0;

        mark = errors;
        wait_valid_pc(32'h1c, 20);
        end_test("sequential", mark);

        mark = errors;
        wait_valid_pc(32'h30, 20);
        end_test("jal", mark);

        // Roughly one stall in four and one hazard in eight
        mark = errors;
        repeat (40) begin
            r        = $random(seed);
            stall_i  = (r[1:0] == 2'b00);
            hazard_i = (r[4:2] == 3'b000);
            next_cycle();
        end
        stall_i  = 1'b0;
        hazard_i = 1'b0;
        repeat (3) next_cycle();
        end_test("stall_hazard", mark);

        mark = errors;
        pulse_trap(1'b0, 1'b1, 32'h0, handler_addr);
        wait_valid_pc(handler_addr, 10);
        repeat (4) next_cycle();
        end_test("exception", mark);

        // Plain return first, then one raised together with an exception
        mark = errors;
        pulse_trap(1'b1, 1'b0, 32'h40, handler_addr);
        wait_valid_pc(32'h40, 10);
        repeat (2) next_cycle();
        pulse_trap(1'b1, 1'b1, 32'h60, handler_addr);
        wait_valid_pc(32'h60, 10);
        repeat (4) next_cycle();
        end_test("mret", mark);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
